// ==== Makefile ====
all: run

run:
	verilator --binary --timing --assert -f flist.f --top-module tb_pipeline -o sim
	./obj_dir/sim | tee sim.log
	grep -q "^TEST PASS$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module pipeline

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== flist.f ====
+incdir+hdl
hdl/core_pkg.sv
hdl/core_ifs.sv
hdl/decode.sv
hdl/inst_queue.sv
hdl/issue.sv
hdl/ex_alu.sv
hdl/rob.sv
hdl/rfile.sv
hdl/pipeline.sv
tb/tb_pipeline.sv

// ==== hdl/core_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

interface iq_if;
  import core_pkg::*;

  logic      push;
  dec_inst_t push_entry;
  logic      full;
  dec_inst_t head_entry;
  logic      empty;
  logic      pop;

  modport decode (
    output push,
    output push_entry,
    input  full
  );

  modport queue (
    input  push,
    input  push_entry,
    input  pop,
    output full,
    output head_entry,
    output empty
  );

  modport issue (
    input  head_entry,
    input  empty,
    output pop
  );

endinterface

// Operand lookup, answered combinationally by the ROB
interface rob_lookup_if;
  import core_pkg::*;

  rob_idx_t slot;
  reg_idx_t a_reg;
  reg_idx_t b_reg;
  word_t    a_val;
  word_t    b_val;
  logic     a_wait;
  logic     b_wait;

  modport issue (
    output slot,
    output a_reg,
    output b_reg,
    input  a_val,
    input  b_val,
    input  a_wait,
    input  b_wait
  );

  modport rob (
    input  slot,
    input  a_reg,
    input  b_reg,
    output a_val,
    output b_val,
    output a_wait,
    output b_wait
  );

endinterface

`default_nettype wire

// ==== hdl/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data word width
`define CORE_XLEN 32
// Architectural registers
`define CORE_REGS 32
`define CORE_IQ_DEPTH 8
// Power of two so that slot arithmetic wraps
`define CORE_ROB_DEPTH 8

`endif

// ==== hdl/core_pkg.sv ====
`default_nettype none

`include "core_macros.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [$clog2(`CORE_REGS)-1:0] reg_idx_t;
  typedef logic [$clog2(`CORE_ROB_DEPTH)-1:0] rob_idx_t;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4
  } alu_op_e;

  typedef struct packed {
    alu_op_e  op;
    reg_idx_t a_reg;
    reg_idx_t b_reg;
    logic     use_imm;
    word_t    imm;
    reg_idx_t dest;
    logic     dest_valid;
    rob_idx_t slot;
  } dec_inst_t;

  // Dest is zero for entries that write no register
  typedef struct packed {
    logic     busy;
    logic     done;
    reg_idx_t dest;
    word_t    result;
  } rob_entry_t;

endpackage

`default_nettype wire

// ==== hdl/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode (
  input  logic               clock,
  input  logic               rst_n,
  input  core_pkg::word_t    inst_word,
  input  logic               inst_valid,
  output logic               stall,
  iq_if.decode               iq,
  output logic               rob_reserve,
  output core_pkg::reg_idx_t rob_dest,
  output logic               rob_dest_valid,
  input  core_pkg::rob_idx_t rob_tail,
  input  logic               rob_full
);
  import core_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  logic      accept;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_e   r_op;
  logic      r_ok;
  dec_inst_t inst;

  assign opcode = inst_word[6:0];
  assign funct3 = inst_word[14:12];
  assign funct7 = inst_word[31:25];

  assign stall  = iq.full || rob_full;
  assign accept = inst_valid && !stall;

  // R-type op select
  always_comb begin
    r_op = alu_add;
    r_ok = 1'b1;
    case ({funct7, funct3})
      {7'b0000000, 3'b000}: r_op = alu_add;
      {7'b0100000, 3'b000}: r_op = alu_sub;
      {7'b0000000, 3'b100}: r_op = alu_xor;
      {7'b0000000, 3'b110}: r_op = alu_or;
      {7'b0000000, 3'b111}: r_op = alu_and;
      default:              r_ok = 1'b0;
    endcase
  end

  // Unsupported words fall through as x0 + 0 with no destination
  always_comb begin
    inst = '0;
    inst.op = alu_add;
    inst.use_imm = 1'b1;
    inst.slot = rob_tail;
    if (opcode == OPC_OP && r_ok) begin
      inst.op = r_op;
      inst.a_reg = inst_word[19:15];
      inst.b_reg = inst_word[24:20];
      inst.use_imm = 1'b0;
      inst.dest = inst_word[11:7];
      inst.dest_valid = 1'b1;
    end else if (opcode == OPC_OP_IMM && funct3 == 3'b000) begin
      inst.a_reg = inst_word[19:15];
      inst.imm = word_t'(signed'(inst_word[31:20]));
      inst.dest = inst_word[11:7];
      inst.dest_valid = 1'b1;
    end
  end

  assign iq.push        = accept;
  assign iq.push_entry  = inst;
  assign rob_reserve    = accept;
  assign rob_dest       = inst.dest;
  assign rob_dest_valid = inst.dest_valid;

  // A word refused during stall is offered again unchanged
  assert property (@(posedge clock) disable iff (!rst_n)
    inst_valid && stall |=> inst_valid && $stable(inst_word));

endmodule

`default_nettype wire

// ==== hdl/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                ex_valid,
  input  core_pkg::dec_inst_t ex_inst,
  input  core_pkg::word_t     ex_a,
  input  core_pkg::word_t     ex_b,
  output logic                res_valid,
  output core_pkg::rob_idx_t  res_slot,
  output core_pkg::word_t     res_data
);
  import core_pkg::*;

  word_t result;

  always_comb begin
    case (ex_inst.op)
      alu_sub: result = ex_a - ex_b;
      alu_and: result = ex_a & ex_b;
      alu_or:  result = ex_a | ex_b;
      alu_xor: result = ex_a ^ ex_b;
      default: result = ex_a + ex_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_valid) begin
      res_slot <= ex_inst.slot;
      res_data <= result;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/inst_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module inst_queue (
  input logic clock,
  input logic rst_n,
  iq_if.queue iq
);
  import core_pkg::*;

  localparam int DEPTH = `CORE_IQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  dec_inst_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign iq.full       = (count == CNT_W'(DEPTH));
  assign iq.empty      = (count == '0);
  assign iq.head_entry = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (iq.push) begin
      mem[wr_ptr] <= iq.push_entry;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (iq.push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (iq.pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(iq.push) - CNT_W'(iq.pop);
    end
  end

  // Decode must see full before pushing
  assert property (@(posedge clock) disable iff (!rst_n) iq.push |-> !iq.full);

endmodule

`default_nettype wire

// ==== hdl/issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue (
  input  logic                clock,
  input  logic                rst_n,
  iq_if.issue                 iq,
  rob_lookup_if.issue         lk,
  output core_pkg::reg_idx_t  rf_a_reg,
  output core_pkg::reg_idx_t  rf_b_reg,
  input  core_pkg::word_t     rf_a_val,
  input  core_pkg::word_t     rf_b_val,
  output logic                ex_valid,
  output core_pkg::dec_inst_t ex_inst,
  output core_pkg::word_t     ex_a,
  output core_pkg::word_t     ex_b
);
  import core_pkg::*;

  dec_inst_t head_inst;
  logic      go;

  assign head_inst = iq.head_entry;

  // Sources go to the register file and the ROB in parallel
  assign rf_a_reg = head_inst.a_reg;
  assign rf_b_reg = head_inst.b_reg;
  assign lk.a_reg = head_inst.a_reg;
  assign lk.b_reg = head_inst.b_reg;
  // Only entries older than the head itself may forward
  assign lk.slot  = head_inst.slot;

  assign go     = !iq.empty && !lk.a_wait && !lk.b_wait;
  assign iq.pop = go;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= go;
    end
  end

  always_ff @(posedge clock) begin
    if (go) begin
      ex_inst <= head_inst;
      ex_a <= lk.a_val;
      ex_b <= head_inst.use_imm ? head_inst.imm : lk.b_val;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module pipeline (
  input  logic                           clock,
  input  logic                           rst_n,
  input  logic [`CORE_XLEN-1:0]          inst_word,
  input  logic                           inst_valid,
  output logic                           stall,
  output logic                           retire_valid,
  output logic [$clog2(`CORE_REGS)-1:0]  retire_reg,
  output logic [`CORE_XLEN-1:0]          retire_data
);

  localparam int XLEN  = `CORE_XLEN;
  localparam int REG_W = $clog2(`CORE_REGS);
  localparam int ROB_W = $clog2(`CORE_ROB_DEPTH);
  // Packed decoded instruction: op, a, b, use_imm, imm, dest, dest_valid, slot
  localparam int DEC_W = 3 + 3 * REG_W + 2 + XLEN + ROB_W;

  logic             rob_reserve;
  logic [REG_W-1:0] rob_dest;
  logic             rob_dest_valid;
  logic [ROB_W-1:0] rob_tail;
  logic             rob_full;

  logic [REG_W-1:0] rf_a_reg;
  logic [REG_W-1:0] rf_b_reg;
  logic [XLEN-1:0]  rf_a_val;
  logic [XLEN-1:0]  rf_b_val;

  logic             ex_valid;
  logic [DEC_W-1:0] ex_inst;
  logic [XLEN-1:0]  ex_a;
  logic [XLEN-1:0]  ex_b;

  logic             res_valid;
  logic [ROB_W-1:0] res_slot;
  logic [XLEN-1:0]  res_data;

  iq_if         iq ();
  rob_lookup_if lk ();

  decode decode_i (
    .clock          (clock),
    .rst_n          (rst_n),
    .inst_word      (inst_word),
    .inst_valid     (inst_valid),
    .stall          (stall),
    .iq             (iq),
    .rob_reserve    (rob_reserve),
    .rob_dest       (rob_dest),
    .rob_dest_valid (rob_dest_valid),
    .rob_tail       (rob_tail),
    .rob_full       (rob_full)
  );

  inst_queue inst_queue_i (
    .clock (clock),
    .rst_n (rst_n),
    .iq    (iq)
  );

  issue issue_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .iq       (iq),
    .lk       (lk),
    .rf_a_reg (rf_a_reg),
    .rf_b_reg (rf_b_reg),
    .rf_a_val (rf_a_val),
    .rf_b_val (rf_b_val),
    .ex_valid (ex_valid),
    .ex_inst  (ex_inst),
    .ex_a     (ex_a),
    .ex_b     (ex_b)
  );

  // Read ports serve issue and the ROB lookup fallback
  rfile rfile_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .a_reg   (rf_a_reg),
    .b_reg   (rf_b_reg),
    .a_val   (rf_a_val),
    .b_val   (rf_b_val),
    .wr_en   (retire_valid),
    .wr_reg  (retire_reg),
    .wr_data (retire_data)
  );

  ex_alu ex_alu_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .ex_valid  (ex_valid),
    .ex_inst   (ex_inst),
    .ex_a      (ex_a),
    .ex_b      (ex_b),
    .res_valid (res_valid),
    .res_slot  (res_slot),
    .res_data  (res_data)
  );

  rob rob_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .reserve      (rob_reserve),
    .dest         (rob_dest),
    .dest_valid   (rob_dest_valid),
    .tail         (rob_tail),
    .full         (rob_full),
    .res_valid    (res_valid),
    .res_slot     (res_slot),
    .res_data     (res_data),
    .lk           (lk),
    .rf_a_val     (rf_a_val),
    .rf_b_val     (rf_b_val),
    .retire_valid (retire_valid),
    .retire_reg   (retire_reg),
    .retire_data  (retire_data)
  );

endmodule

`default_nettype wire

// ==== hdl/rfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module rfile (
  input  logic               clock,
  input  logic               rst_n,
  input  core_pkg::reg_idx_t a_reg,
  input  core_pkg::reg_idx_t b_reg,
  output core_pkg::word_t    a_val,
  output core_pkg::word_t    b_val,
  input  logic               wr_en,
  input  core_pkg::reg_idx_t wr_reg,
  input  core_pkg::word_t    wr_data
);
  import core_pkg::*;

  word_t regs [`CORE_REGS];

  assign a_val = (a_reg == '0) ? '0 : regs[a_reg];
  assign b_val = (b_reg == '0) ? '0 : regs[b_reg];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < `CORE_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_reg != '0) begin
      regs[wr_reg] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rob.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module rob (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               reserve,
  input  core_pkg::reg_idx_t dest,
  input  logic               dest_valid,
  output core_pkg::rob_idx_t tail,
  output logic               full,
  input  logic               res_valid,
  input  core_pkg::rob_idx_t res_slot,
  input  core_pkg::word_t    res_data,
  rob_lookup_if.rob          lk,
  input  core_pkg::word_t    rf_a_val,
  input  core_pkg::word_t    rf_b_val,
  output logic               retire_valid,
  output core_pkg::reg_idx_t retire_reg,
  output core_pkg::word_t    retire_data
);
  import core_pkg::*;

  localparam int DEPTH = `CORE_ROB_DEPTH;
  localparam int CNT_W = $clog2(DEPTH) + 1;

  rob_entry_t       ents [DEPTH];
  rob_idx_t         head;
  logic [CNT_W-1:0] count;

  assign full = (count == CNT_W'(DEPTH));

  // Youngest busy entry older than lk.slot writing r, else the rfile value
  function automatic void find(input reg_idx_t r, input word_t rf_val,
                               output word_t val, output logic wt);
    rob_idx_t lim;
    rob_idx_t idx;
    lim = lk.slot - head;
    val = rf_val;
    wt = 1'b0;
    for (int age = 0; age < DEPTH; age++) begin
      idx = head + rob_idx_t'(age);
      if (rob_idx_t'(age) < lim && ents[idx].busy && r != '0 && ents[idx].dest == r) begin
        val = ents[idx].result;
        wt = !ents[idx].done;
      end
    end
  endfunction

  always_comb begin
    find(lk.a_reg, rf_a_val, lk.a_val, lk.a_wait);
    find(lk.b_reg, rf_b_val, lk.b_val, lk.b_wait);
  end

  // Head retires as soon as it is done
  assign retire_valid = ents[head].busy && ents[head].done;
  assign retire_reg   = ents[head].dest;
  assign retire_data  = (ents[head].dest == '0) ? '0 : ents[head].result;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        ents[i].busy <= 1'b0;
        ents[i].done <= 1'b0;
      end
    end else begin
      if (reserve) begin
        ents[tail].busy <= 1'b1;
        ents[tail].done <= 1'b0;
        ents[tail].dest <= dest_valid ? dest : '0;
        tail <= tail + 1'b1;
      end
      if (res_valid) begin
        ents[res_slot].done <= 1'b1;
        ents[res_slot].result <= res_data;
      end
      if (retire_valid) begin
        ents[head].busy <= 1'b0;
        head <= head + 1'b1;
      end
      count <= count + CNT_W'(reserve) - CNT_W'(retire_valid);
    end
  end

  // ALU results land only on slots still waiting for them
  assert property (@(posedge clock) disable iff (!rst_n)
    res_valid |-> ents[res_slot].busy && !ents[res_slot].done);

  assert property (@(posedge clock) disable iff (!rst_n) reserve |-> !full);

endmodule

`default_nettype wire

// ==== tb/tb_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module tb_pipeline;

  localparam int REG_W = $clog2(`CORE_REGS);
  localparam int DRIVE_LIMIT = 100;
  localparam int RETIRE_LIMIT = 400;

  logic                  clock;
  logic                  rst_n;
  logic [`CORE_XLEN-1:0] inst_word;
  logic                  inst_valid;
  logic                  stall;
  logic                  retire_valid;
  logic [REG_W-1:0]      retire_reg;
  logic [`CORE_XLEN-1:0] retire_data;

  // Program in order, with the expected retire register and value per word
  logic [`CORE_XLEN-1:0] tab_word [$];
  logic [REG_W-1:0]      tab_reg [$];
  logic [`CORE_XLEN-1:0] tab_data [$];
  int                    test_first [7];
  int                    test_last [7];
  string                 test_name [7];

  logic [`CORE_XLEN-1:0] model_regs [`CORE_REGS];

  int retire_count;
  int errors;
  int checks;
  int failed_tests;
  bit stall_seen;
  bit timed_out;

  pipeline pipeline_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .inst_word    (inst_word),
    .inst_valid   (inst_valid),
    .stall        (stall),
    .retire_valid (retire_valid),
    .retire_reg   (retire_reg),
    .retire_data  (retire_data)
  );

  always #2 clock = ~clock;

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  // Kind 0..4 is add, sub, and, or, xor
  function automatic logic [31:0] enc_op(input int kind, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = 7'b0000000;
    f3 = 3'b000;
    case (kind)
      1: f7 = 7'b0100000;
      2: f3 = 3'b111;
      3: f3 = 3'b110;
      4: f3 = 3'b100;
      default: f3 = 3'b000;
    endcase
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  // Reference model for one word in program order
  function automatic void add_inst(input logic [31:0] w);
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    bit          ok;
    rd = w[11:7];
    a = model_regs[w[19:15]];
    b = model_regs[w[24:20]];
    res = '0;
    ok = 1'b1;
    if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
      res = a + {{20{w[31]}}, w[31:20]};
    end else if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0100000 && w[14:12] == 3'b000) begin
      res = a - b;
    end else if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0000000) begin
      case (w[14:12])
        3'b000: res = a + b;
        3'b111: res = a & b;
        3'b110: res = a | b;
        3'b100: res = a ^ b;
        default: ok = 1'b0;
      endcase
    end else begin
      ok = 1'b0;
    end
    if (!ok || rd == 5'd0) begin
      rd = '0;
      res = '0;
    end
    if (rd != 5'd0) begin
      model_regs[rd] = res;
    end
    tab_word.push_back(w);
    tab_reg.push_back(rd);
    tab_data.push_back(res);
  endfunction

  task automatic build_table();
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    test_name[1] = "idle after reset";
    test_first[2] = tab_word.size();
    test_name[2] = "seeds and independent ops";
    add_inst(enc_addi(1, 0, 12'h123));
    add_inst(enc_addi(2, 0, 12'h7ff));
    add_inst(enc_addi(3, 0, 12'hf00));
    add_inst(enc_addi(4, 0, 12'h055));
    add_inst(enc_op(0, 5, 1, 2));
    add_inst(enc_op(1, 6, 1, 3));
    add_inst(enc_op(2, 7, 2, 4));
    add_inst(enc_op(3, 8, 3, 4));
    add_inst(enc_op(4, 9, 2, 3));
    test_last[2] = tab_word.size() - 1;
    test_first[3] = tab_word.size();
    test_name[3] = "dependent chains";
    add_inst(enc_addi(10, 1, 12'h005));
    add_inst(enc_op(0, 11, 10, 2));
    add_inst(enc_op(1, 12, 11, 10));
    add_inst(enc_op(4, 13, 12, 11));
    add_inst(enc_op(2, 14, 13, 3));
    add_inst(enc_op(3, 15, 14, 12));
    add_inst(enc_addi(15, 15, 12'hfff));
    add_inst(enc_op(0, 15, 15, 15));
    test_last[3] = tab_word.size() - 1;
    test_first[4] = tab_word.size();
    test_name[4] = "x0 writes and reads";
    add_inst(enc_addi(0, 1, 12'h063));
    add_inst(enc_op(0, 0, 1, 2));
    add_inst(enc_op(0, 16, 0, 0));
    add_inst(enc_addi(17, 0, 12'h007));
    add_inst(enc_op(1, 18, 0, 17));
    // LUI is not supported and retires as a no-op
    add_inst(32'h123450b7);
    add_inst(enc_op(3, 19, 0, 1));
    test_last[4] = tab_word.size() - 1;
    test_first[5] = tab_word.size();
    test_name[5] = "30 back-to-back with stall";
    for (int i = 0; i < 30; i++) begin
      if (i % 2 == 0) begin
        add_inst(enc_addi(20, 20, 12'(i * 3 + 1)));
      end else begin
        add_inst(enc_op(i % 5, 21, 20, 21));
      end
    end
    test_last[5] = tab_word.size() - 1;
    test_first[6] = tab_word.size();
    test_name[6] = "64 random ops";
    for (int i = 0; i < 64; i++) begin
      kind = int'($urandom_range(5, 0));
      rd = 5'($urandom_range(15, 0));
      rs1 = 5'($urandom_range(15, 0));
      rs2 = 5'($urandom_range(15, 0));
      if (kind == 5) begin
        add_inst(enc_addi(rd, rs1, 12'($urandom)));
      end else begin
        add_inst(enc_op(kind, rd, rs1, rs2));
      end
    end
    test_last[6] = tab_word.size() - 1;
  endtask

  // Retire monitor
  always @(negedge clock) begin
    if (rst_n) begin
      if (stall) begin
        stall_seen = 1'b1;
      end
      if (retire_valid) begin
        if (retire_count >= tab_word.size()) begin
          $display("Retire pulse at %0t ns with no instruction left to retire", $time);
          errors++;
        end else begin
          checks++;
          if (retire_reg !== tab_reg[retire_count]) begin
            $display("Fail at %0t ns: retire_reg got %0d, expected %0d",
                     $time, retire_reg, tab_reg[retire_count]);
            errors++;
          end
          if (retire_data !== tab_data[retire_count]) begin
            $display("Fail at %0t ns: retire_data got %h, expected %h",
                     $time, retire_data, tab_data[retire_count]);
            errors++;
          end
        end
        retire_count++;
      end
    end
  end

  task automatic report(input int t, input int err);
    if (err != 0) begin
      failed_tests++;
    end
    $display("Test %0d %s: %s, %0d errors", t, test_name[t], (err == 0) ? "ok" : "failed", err);
  endtask

  // Offer each word until accepted, holding it while stall is high
  task automatic drive_range(input int first, input int last);
    int idx;
    int wait_cycles;
    bit taken;
    idx = first;
    wait_cycles = 0;
    while (idx <= last && !timed_out) begin
      inst_word <= tab_word[idx];
      inst_valid <= 1'b1;
      @(negedge clock);
      taken = !stall;
      @(posedge clock);
      if (taken) begin
        idx++;
        wait_cycles = 0;
      end else begin
        wait_cycles++;
        if (wait_cycles > DRIVE_LIMIT) begin
          $display("Timeout: stall stayed high for %0d cycles at word %0d", wait_cycles, idx);
          errors++;
          timed_out = 1'b1;
        end
      end
    end
    inst_valid <= 1'b0;
  endtask

  task automatic check_idle();
    int err0;
    err0 = errors;
    repeat (20) begin
      @(negedge clock);
      checks++;
      if (stall !== 1'b0) begin
        $display("Fail at %0t ns: stall got %b, expected 0", $time, stall);
        errors++;
      end
      if (retire_valid !== 1'b0) begin
        $display("Fail at %0t ns: retire_valid got %b, expected 0", $time, retire_valid);
        errors++;
      end
    end
    @(posedge clock);
    report(1, errors - err0);
  endtask

  task automatic run_test(input int t);
    int err0;
    int wait_cycles;
    if (timed_out) begin
      return;
    end
    err0 = errors;
    stall_seen = 1'b0;
    drive_range(test_first[t], test_last[t]);
    wait_cycles = 0;
    while (!timed_out && retire_count <= test_last[t]) begin
      @(posedge clock);
      wait_cycles++;
      if (wait_cycles > RETIRE_LIMIT) begin
        $display("Timeout: test %0d still waiting for retires after %0d cycles", t, wait_cycles);
        errors++;
        timed_out = 1'b1;
      end
    end
    // Extra retires would show up during these settle cycles
    repeat (8) @(posedge clock);
    if (retire_count != test_last[t] + 1) begin
      $display("Test %0d saw %0d retires in total, expected %0d", t, retire_count,
               test_last[t] + 1);
      errors++;
    end
    if (t == 5 && !stall_seen) begin
      $display("Test 5 never saw stall go high");
      errors++;
    end
    report(t, errors - err0);
  endtask

  initial begin
    clock = 1'b0;
    rst_n = 1'b0;
    inst_word = '0;
    inst_valid = 1'b0;
    retire_count = 0;
    errors = 0;
    checks = 0;
    failed_tests = 0;
    stall_seen = 1'b0;
    timed_out = 1'b0;
    void'($urandom(32'h91fe6aa1));
    for (int r = 0; r < `CORE_REGS; r++) begin
      model_regs[r] = '0;
    end
    build_table();
    repeat (16) @(posedge clock);
    rst_n <= 1'b1;
    check_idle();
    for (int t = 2; t <= 6; t++) begin
      run_test(t);
    end
    repeat (4) @(posedge clock);
    $display("Summary: 6 tests, %0d failed, %0d checks, %0d errors, %0d of %0d retired",
             failed_tests, checks, errors, retire_count, tab_word.size());
    if (errors == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
